// ==== simd_settings.svh ====
////////////////////
// Word and lane geometry of the packed-SIMD unit, plus the saturation bounds
// Included by the package, by RTL that needs the bounds, and by the testbench
////////////////////
`ifndef SIMD_SETTINGS_SVH
`define SIMD_SETTINGS_SVH

// Word and lane geometry
`define SIMD_XLEN   32
`define SIMD_BYTE   8
`define SIMD_NBYTES 4

// Saturation bounds per lane width
`define SIMD_SAT_S8_MIN  8'h80
`define SIMD_SAT_S8_MAX  8'h7f
`define SIMD_SAT_S16_MIN 16'h8000
`define SIMD_SAT_S16_MAX 16'h7fff
`define SIMD_SAT_S32_MIN 32'h8000_0000
`define SIMD_SAT_S32_MAX 32'h7fff_ffff
`define SIMD_SAT_U8_MAX  8'hff

`endif

// ==== simd_pkg.sv ====
////////////////////
// Opcode, lane and control types shared by the SIMD datapath
// Also holds two small lane-mask helpers used by several blocks
////////////////////
`include "simd_settings.svh"
`default_nettype none

package simd_pkg;

  typedef enum logic [5:0] {
    ADD8,   ADD16,   ADD32,   SUB8,    SUB16,   SUB32,
    RADD8,  RADD16,  RADD32,  URADD8,  URADD16, URADD32,
    RSUB8,  RSUB16,  RSUB32,  URSUB8,  URSUB16, URSUB32,
    KADD8,  KADD16,  KADD32,  UKADD8,  UKADD16, UKADD32,
    KSUB8,  KSUB16,  KSUB32,  UKSUB8,  UKSUB16, UKSUB32,
    CMPEQ,  SCMPLT,  UCMPLT,  SCMPLE,  UCMPLE,
    SMIN,   UMIN,    SMAX,    UMAX
  } simd_op_e;

  typedef enum logic [1:0] {W8 = 2'd0, W16 = 2'd1, W32 = 2'd2} lane_width_e;

  typedef enum logic [2:0] {
    MODE_WRAP, MODE_HALVE, MODE_SAT, MODE_CMP, MODE_MINMAX
  } result_mode_e;

  typedef enum logic [1:0] {CMP_EQ, CMP_LT, CMP_LE, CMP_MIN_MAX} cmp_kind_e;

  typedef struct packed {
    lane_width_e  width;
    logic         is_signed;
    logic         subtract;
    result_mode_e mode;
    cmp_kind_e    cmp_kind;
    logic         pick_max;
  } simd_ctrl_t;

  typedef struct packed {
    simd_op_e              op;
    lane_width_e           width;
    logic [`SIMD_XLEN-1:0] operand_a;
    logic [`SIMD_XLEN-1:0] operand_b;
  } simd_req_t;

  typedef struct packed {
    logic [`SIMD_XLEN-1:0]   sum;
    logic [`SIMD_NBYTES-1:0] lane_top;
  } simd_sum_t;

  // Bytes that hold the top of a lane
  function automatic logic [`SIMD_NBYTES-1:0] top_byte_mask(lane_width_e width);
    case (width)
      W8:      return 4'b1111;
      W16:     return 4'b1010;
      default: return 4'b1000;
    endcase
  endfunction

  // Copy the flag of each lane's top byte over the whole lane
  function automatic logic [`SIMD_NBYTES-1:0] spread_top(logic [`SIMD_NBYTES-1:0] flags,
                                                        lane_width_e width);
    case (width)
      W8:      return flags;
      W16:     return {{2{flags[3]}}, {2{flags[1]}}};
      default: return {4{flags[3]}};
    endcase
  endfunction

endpackage

`default_nettype wire

// ==== simd_op_decode.sv ====
////////////////////
// Opcode decoder that turns an opcode into datapath control
// Compare and min/max codes take their lane width from width_i
////////////////////
`default_nettype none

module simd_op_decode (
  input  simd_pkg::simd_op_e    op_i,
  input  simd_pkg::lane_width_e width_i,
  output simd_pkg::simd_ctrl_t  ctrl_o
);

  import simd_pkg::*;

  lane_width_e cmp_width;

  // Reserved width code falls back to a full word
  always_comb begin
    case (width_i)
      W8:      cmp_width = W8;
      W16:     cmp_width = W16;
      default: cmp_width = W32;
    endcase
  end

  always_comb begin
    ctrl_o = '{width: W32, is_signed: 1'b0, subtract: 1'b0, mode: MODE_WRAP,
               cmp_kind: CMP_EQ, pick_max: 1'b0};

    // Lane width
    case (op_i)
      ADD8, SUB8, RADD8, URADD8, RSUB8, URSUB8,
      KADD8, UKADD8, KSUB8, UKSUB8:             ctrl_o.width = W8;
      ADD16, SUB16, RADD16, URADD16, RSUB16, URSUB16,
      KADD16, UKADD16, KSUB16, UKSUB16:         ctrl_o.width = W16;
      CMPEQ, SCMPLT, UCMPLT, SCMPLE, UCMPLE,
      SMIN, UMIN, SMAX, UMAX:                   ctrl_o.width = cmp_width;
      default: ;
    endcase

    // Signed lanes
    case (op_i)
      RADD8, RADD16, RADD32, RSUB8, RSUB16, RSUB32,
      KADD8, KADD16, KADD32, KSUB8, KSUB16, KSUB32,
      SCMPLT, SCMPLE, SMIN, SMAX:               ctrl_o.is_signed = 1'b1;
      default: ;
    endcase

    // Every compare runs the adder as a subtractor
    case (op_i)
      SUB8, SUB16, SUB32, RSUB8, RSUB16, RSUB32,
      URSUB8, URSUB16, URSUB32, KSUB8, KSUB16, KSUB32,
      UKSUB8, UKSUB16, UKSUB32,
      CMPEQ, SCMPLT, UCMPLT, SCMPLE, UCMPLE,
      SMIN, UMIN, SMAX, UMAX:                   ctrl_o.subtract = 1'b1;
      default: ;
    endcase

    // Result mode and compare kind
    case (op_i)
      RADD8, RADD16, RADD32, URADD8, URADD16, URADD32,
      RSUB8, RSUB16, RSUB32, URSUB8, URSUB16, URSUB32: ctrl_o.mode = MODE_HALVE;
      KADD8, KADD16, KADD32, UKADD8, UKADD16, UKADD32,
      KSUB8, KSUB16, KSUB32, UKSUB8, UKSUB16, UKSUB32: ctrl_o.mode = MODE_SAT;
      CMPEQ:          ctrl_o.mode = MODE_CMP;
      SCMPLT, UCMPLT: begin
        ctrl_o.mode     = MODE_CMP;
        ctrl_o.cmp_kind = CMP_LT;
      end
      SCMPLE, UCMPLE: begin
        ctrl_o.mode     = MODE_CMP;
        ctrl_o.cmp_kind = CMP_LE;
      end
      SMIN, UMIN, SMAX, UMAX: begin
        ctrl_o.mode     = MODE_MINMAX;
        ctrl_o.cmp_kind = CMP_MIN_MAX;
        ctrl_o.pick_max = (op_i == SMAX) || (op_i == UMAX);
      end
      default: ;
    endcase
  end

endmodule

`default_nettype wire

// ==== simd_adder.sv ====
////////////////////
// Lane-partitioned adder built from four 9-bit byte adders
// Carry only crosses a byte edge that lies inside a lane
////////////////////
`include "simd_settings.svh"
`default_nettype none

module simd_adder (
  input  logic [`SIMD_XLEN-1:0] operand_a_i,
  input  logic [`SIMD_XLEN-1:0] operand_b_i,
  input  simd_pkg::simd_ctrl_t  ctrl_i,
  output simd_pkg::simd_sum_t   sum_o
);

  import simd_pkg::*;

  logic [`SIMD_NBYTES-1:0] top;

  assign top = top_byte_mask(ctrl_i.width);

  ////////////////////
  // Byte adders
  ////////////////////
  // Only a lane's top byte gets a real extension bit. The B extension is
  // inverted with B on subtract, so the ninth bit is the exact lane sign
  // for unsigned subtract as well.
  always_comb begin
    logic       carry;
    logic       ext_a;
    logic       ext_b;
    logic [8:0] add_a;
    logic [8:0] add_b;
    logic [8:0] byte_sum;

    carry = ctrl_i.subtract;
    for (int b = 0; b < `SIMD_NBYTES; b++) begin
      ext_a    = top[b] & ctrl_i.is_signed & operand_a_i[`SIMD_BYTE*b+7];
      ext_b    = top[b] & ((ctrl_i.is_signed & operand_b_i[`SIMD_BYTE*b+7]) ^ ctrl_i.subtract);
      add_a    = {ext_a, operand_a_i[`SIMD_BYTE*b +: `SIMD_BYTE]};
      add_b    = {ext_b, operand_b_i[`SIMD_BYTE*b +: `SIMD_BYTE] ^ {`SIMD_BYTE{ctrl_i.subtract}}};
      byte_sum = add_a + add_b + {8'h00, carry};

      sum_o.sum[`SIMD_BYTE*b +: `SIMD_BYTE] = byte_sum[7:0];
      sum_o.lane_top[b]                     = byte_sum[8];

      // Next byte starts a new lane after a top byte
      carry = top[b] ? ctrl_i.subtract : byte_sum[8];
    end
  end

endmodule

`default_nettype wire

// ==== simd_lane_post.sv ====
////////////////////
// Lane result post-processing for wrap, halving and saturation
// overflow_o flags any clamped lane, the handshake qualifies it by mode
////////////////////
`include "simd_settings.svh"
`default_nettype none

module simd_lane_post (
  input  simd_pkg::simd_sum_t   sum_i,
  input  simd_pkg::simd_ctrl_t  ctrl_i,
  output logic [`SIMD_XLEN-1:0] result_o,
  output logic                  overflow_o
);

  import simd_pkg::*;

  logic [`SIMD_NBYTES-1:0] top;
  logic [`SIMD_NBYTES-1:0] lane_over;
  logic [`SIMD_NBYTES-1:0] clamp;
  logic [`SIMD_XLEN:0]     sum_ext;
  logic [`SIMD_XLEN-1:0]   halved;
  logic [`SIMD_XLEN-1:0]   bound;
  logic [`SIMD_XLEN-1:0]   saturated;

  assign top     = top_byte_mask(ctrl_i.width);
  assign sum_ext = {sum_i.lane_top[`SIMD_NBYTES-1], sum_i.sum};

  // Halving, shift right by one inside each lane
  always_comb begin
    for (int b = 0; b < `SIMD_NBYTES; b++) begin
      halved[`SIMD_BYTE*b +: 7] = sum_ext[`SIMD_BYTE*b+1 +: 7];
      halved[`SIMD_BYTE*b+7]    = top[b] ? sum_i.lane_top[b] : sum_ext[`SIMD_BYTE*b+8];
    end
  end

  ////////////////////
  // Saturation
  ////////////////////
  // Signed lane overflows when the extra bit differs from the lane MSB
  always_comb begin
    for (int b = 0; b < `SIMD_NBYTES; b++) begin
      lane_over[b] = top[b] & (ctrl_i.is_signed ?
                               (sum_i.lane_top[b] ^ sum_i.sum[`SIMD_BYTE*b+7]) :
                               sum_i.lane_top[b]);
    end
  end

  assign clamp = spread_top(lane_over, ctrl_i.width);

  // Bound picked by direction of the exact result
  always_comb begin
    bound = '0;
    if (!ctrl_i.is_signed) begin
      bound = ctrl_i.subtract ? '0 : {`SIMD_NBYTES{`SIMD_SAT_U8_MAX}};
    end else begin
      case (ctrl_i.width)
        W8: begin
          for (int b = 0; b < `SIMD_NBYTES; b++) begin
            bound[`SIMD_BYTE*b +: `SIMD_BYTE] =
              sum_i.lane_top[b] ? `SIMD_SAT_S8_MIN : `SIMD_SAT_S8_MAX;
          end
        end
        W16: bound = {sum_i.lane_top[3] ? `SIMD_SAT_S16_MIN : `SIMD_SAT_S16_MAX,
                      sum_i.lane_top[1] ? `SIMD_SAT_S16_MIN : `SIMD_SAT_S16_MAX};
        default: bound = sum_i.lane_top[3] ? `SIMD_SAT_S32_MIN : `SIMD_SAT_S32_MAX;
      endcase
    end
  end

  always_comb begin
    for (int b = 0; b < `SIMD_NBYTES; b++) begin
      saturated[`SIMD_BYTE*b +: `SIMD_BYTE] = clamp[b] ? bound[`SIMD_BYTE*b +: `SIMD_BYTE] :
                                                         sum_i.sum[`SIMD_BYTE*b +: `SIMD_BYTE];
    end
  end

  always_comb begin
    case (ctrl_i.mode)
      MODE_HALVE: result_o = halved;
      MODE_SAT:   result_o = saturated;
      default:    result_o = sum_i.sum;
    endcase
  end

  assign overflow_o = |lane_over;

endmodule

`default_nettype wire

// ==== simd_compare.sv ====
////////////////////
// Lane-wise compare and min/max from the subtract sum
// Compare masks are all-ones or all-zeros per lane
////////////////////
`include "simd_settings.svh"
`default_nettype none

module simd_compare (
  input  logic [`SIMD_XLEN-1:0] operand_a_i,
  input  logic [`SIMD_XLEN-1:0] operand_b_i,
  input  simd_pkg::simd_sum_t   sum_i,
  input  simd_pkg::simd_ctrl_t  ctrl_i,
  output logic [`SIMD_XLEN-1:0] result_o
);

  import simd_pkg::*;

  logic [`SIMD_NBYTES-1:0] byte_zero;
  logic [`SIMD_NBYTES-1:0] byte_less;
  logic [`SIMD_NBYTES-1:0] lane_eq;
  logic [`SIMD_NBYTES-1:0] lane_less;
  logic [`SIMD_NBYTES-1:0] hit;

  // Per-byte flags, less-than is only meaningful at a lane's top byte
  always_comb begin
    logic sign_a;
    logic sign_b;

    for (int b = 0; b < `SIMD_NBYTES; b++) begin
      sign_a       = operand_a_i[`SIMD_BYTE*b+7];
      sign_b       = operand_b_i[`SIMD_BYTE*b+7];
      byte_zero[b] = (sum_i.sum[`SIMD_BYTE*b +: `SIMD_BYTE] == '0);
      // Differing signs decide without the difference
      if (sign_a == sign_b) begin
        byte_less[b] = sum_i.sum[`SIMD_BYTE*b+7];
      end else begin
        byte_less[b] = ctrl_i.is_signed ? sign_a : sign_b;
      end
    end
  end

  // Equal needs every byte of the lane to be zero
  always_comb begin
    case (ctrl_i.width)
      W8:      lane_eq = byte_zero;
      W16:     lane_eq = {{2{&byte_zero[3:2]}}, {2{&byte_zero[1:0]}}};
      default: lane_eq = {`SIMD_NBYTES{&byte_zero}};
    endcase
  end

  assign lane_less = spread_top(byte_less, ctrl_i.width);

  always_comb begin
    case (ctrl_i.cmp_kind)
      CMP_EQ:  hit = lane_eq;
      CMP_LT:  hit = lane_less;
      CMP_LE:  hit = lane_less | lane_eq;
      // For min/max a set bit selects operand A
      default: hit = ctrl_i.pick_max ? ~lane_less : lane_less;
    endcase
  end

  always_comb begin
    for (int b = 0; b < `SIMD_NBYTES; b++) begin
      if (ctrl_i.cmp_kind == CMP_MIN_MAX) begin
        result_o[`SIMD_BYTE*b +: `SIMD_BYTE] = hit[b] ? operand_a_i[`SIMD_BYTE*b +: `SIMD_BYTE] :
                                                        operand_b_i[`SIMD_BYTE*b +: `SIMD_BYTE];
      end else begin
        result_o[`SIMD_BYTE*b +: `SIMD_BYTE] = {`SIMD_BYTE{hit[b]}};
      end
    end
  end

endmodule

`default_nettype wire

// ==== simd_handshake.sv ====
////////////////////
// Four-phase req/ack front end with one operation in flight
// Captures the request, then registers the selected result one edge later
////////////////////
`include "simd_settings.svh"
`default_nettype none

module simd_handshake (
  input  logic                  clk_i,
  input  logic                  reset_i,
  input  logic                  req_i,
  input  simd_pkg::simd_op_e    op_i,
  input  simd_pkg::lane_width_e width_i,
  input  logic [`SIMD_XLEN-1:0] operand_a_i,
  input  logic [`SIMD_XLEN-1:0] operand_b_i,
  input  simd_pkg::simd_ctrl_t  ctrl_i,
  input  logic [`SIMD_XLEN-1:0] arith_result_i,
  input  logic [`SIMD_XLEN-1:0] cmp_result_i,
  input  logic                  arith_overflow_i,
  output simd_pkg::simd_req_t   issue_o,
  output logic                  ack_o,
  output logic [`SIMD_XLEN-1:0] result_o,
  output logic                  overflow_o
);

  import simd_pkg::*;

  typedef enum logic [1:0] {IDLE, BUSY, DONE} hs_state_e;

  hs_state_e             state_q;
  hs_state_e             state_d;
  simd_req_t             issue_q;
  logic                  ack_q;
  logic [`SIMD_XLEN-1:0] result_q;
  logic                  overflow_q;
  logic                  pick_cmp;

  // IDLE waits for req, BUSY computes, DONE holds ack until req drops
  always_comb begin
    case (state_q)
      IDLE:    state_d = req_i ? BUSY : IDLE;
      BUSY:    state_d = DONE;
      DONE:    state_d = req_i ? DONE : IDLE;
      default: state_d = IDLE;
    endcase
  end

  assign pick_cmp = (ctrl_i.mode == MODE_CMP) || (ctrl_i.mode == MODE_MINMAX);

  always_ff @(posedge clk_i) begin
    if (reset_i) begin
      state_q    <= IDLE;
      ack_q      <= 1'b0;
      result_q   <= '0;
      overflow_q <= 1'b0;
    end else begin
      state_q <= state_d;
      ack_q   <= (state_d == DONE);
      if (state_q == BUSY) begin
        result_q   <= pick_cmp ? cmp_result_i : arith_result_i;
        overflow_q <= (ctrl_i.mode == MODE_SAT) & arith_overflow_i;
      end
    end
  end

  // Operand capture
  always_ff @(posedge clk_i) begin
    if (state_q == IDLE && req_i) begin
      issue_q <= '{op: op_i, width: width_i, operand_a: operand_a_i, operand_b: operand_b_i};
    end
  end

  assign issue_o    = issue_q;
  assign ack_o      = ack_q;
  assign result_o   = result_q;
  assign overflow_o = overflow_q;

  // Ack only answers a request that was still up
  assert property (@(posedge clk_i) disable iff (reset_i) $rose(ack_o) |-> $past(req_i));

endmodule

`default_nettype wire

// ==== simd_alu.sv ====
////////////////////
// Packed-SIMD arithmetic unit, top level
// One req/ack transaction per operation on 8, 16 or 32-bit lanes
////////////////////
`include "simd_settings.svh"
`default_nettype none

module simd_alu (
  input  logic                  clk_i,
  input  logic                  reset_i,
  input  logic                  req_i,
  input  simd_pkg::simd_op_e    op_i,
  input  simd_pkg::lane_width_e width_i,
  input  logic [`SIMD_XLEN-1:0] operand_a_i,
  input  logic [`SIMD_XLEN-1:0] operand_b_i,
  output logic                  ack_o,
  output logic [`SIMD_XLEN-1:0] result_o,
  output logic                  overflow_o
);

  import simd_pkg::*;

  simd_req_t             issue;
  simd_ctrl_t            ctrl;
  simd_sum_t             sum;
  logic [`SIMD_XLEN-1:0] arith_result;
  logic [`SIMD_XLEN-1:0] cmp_result;
  logic                  arith_overflow;

  simd_handshake u_handshake (
    .clk_i            (clk_i),
    .reset_i          (reset_i),
    .req_i            (req_i),
    .op_i             (op_i),
    .width_i          (width_i),
    .operand_a_i      (operand_a_i),
    .operand_b_i      (operand_b_i),
    .ctrl_i           (ctrl),
    .arith_result_i   (arith_result),
    .cmp_result_i     (cmp_result),
    .arith_overflow_i (arith_overflow),
    .issue_o          (issue),
    .ack_o            (ack_o),
    .result_o         (result_o),
    .overflow_o       (overflow_o)
  );

  // Combinational datapath on the captured request
  simd_op_decode u_decode (
    .op_i    (issue.op),
    .width_i (issue.width),
    .ctrl_o  (ctrl)
  );

  simd_adder u_adder (
    .operand_a_i (issue.operand_a),
    .operand_b_i (issue.operand_b),
    .ctrl_i      (ctrl),
    .sum_o       (sum)
  );

  simd_lane_post u_lane_post (
    .sum_i      (sum),
    .ctrl_i     (ctrl),
    .result_o   (arith_result),
    .overflow_o (arith_overflow)
  );

  simd_compare u_compare (
    .operand_a_i (issue.operand_a),
    .operand_b_i (issue.operand_b),
    .sum_i       (sum),
    .ctrl_i      (ctrl),
    .result_o    (cmp_result)
  );

endmodule

`default_nettype wire

// ==== tb_clock.sv ====
////////////////////
// Clock and reset source for the SIMD testbench
// 20 ns clock, reset held over the first five rising edges
////////////////////
`default_nettype none

module tb_clock (
  output logic clk_o,
  output logic reset_o
);

  timeunit 1ns;
  timeprecision 100ps;

  localparam int HALF_PERIOD_NS = 10;
  localparam int RESET_CYCLES   = 5;

  initial begin
    clk_o = 1'b0;
    forever #(HALF_PERIOD_NS) clk_o = ~clk_o;
  end

  // Released on a falling edge, away from the sampling edge
  initial begin
    reset_o <= 1'b1;
    repeat (RESET_CYCLES) @(negedge clk_o);
    reset_o <= 1'b0;
  end

endmodule

`default_nettype wire

// ==== tb_checker.sv ====
////////////////////
// Watches the SIMD unit on falling edges, models every kept opcode
// and checks results, overflow and the req/ack timing
////////////////////
`include "simd_settings.svh"
`default_nettype none

module tb_checker (
  input  logic                  clk_i,
  input  logic                  reset_i,
  input  logic                  req_i,
  input  simd_pkg::simd_op_e    op_i,
  input  simd_pkg::lane_width_e width_i,
  input  logic [`SIMD_XLEN-1:0] operand_a_i,
  input  logic [`SIMD_XLEN-1:0] operand_b_i,
  input  logic                  ack_i,
  input  logic [`SIMD_XLEN-1:0] result_i,
  input  logic                  overflow_i,
  output int                    value_errors_o,
  output int                    protocol_errors_o,
  output int                    checks_o
);

  timeunit 1ns;
  timeprecision 100ps;

  import simd_pkg::*;

  // Result classes of the model
  localparam int CLS_WRAP  = 0;
  localparam int CLS_HALVE = 1;
  localparam int CLS_SAT   = 2;
  localparam int CLS_EQ    = 3;
  localparam int CLS_LT    = 4;
  localparam int CLS_LE    = 5;
  localparam int CLS_MIN   = 6;
  localparam int CLS_MAX   = 7;

  int                    value_errors = 0;
  int                    protocol_errors = 0;
  int                    checks = 0;
  int                    req_edges = 0;
  logic                  ack_prev = 1'b0;
  logic [`SIMD_XLEN-1:0] held_result;
  logic                  held_overflow;

  assign value_errors_o    = value_errors;
  assign protocol_errors_o = protocol_errors;
  assign checks_o          = checks;

  // Clamp value for one lane, masked to the lane by the caller
  function automatic logic [63:0] sat_bound(int lw, bit sgn, bit upper);
    logic [63:0] bound;
    bound = '0;
    if (!sgn) begin
      if (upper) begin
        bound = {32'd0, {`SIMD_NBYTES{`SIMD_SAT_U8_MAX}}};
      end
    end else begin
      case (lw)
        8:       bound = {56'd0, upper ? `SIMD_SAT_S8_MAX : `SIMD_SAT_S8_MIN};
        16:      bound = {48'd0, upper ? `SIMD_SAT_S16_MAX : `SIMD_SAT_S16_MIN};
        default: bound = {32'd0, upper ? `SIMD_SAT_S32_MAX : `SIMD_SAT_S32_MIN};
      endcase
    end
    return bound;
  endfunction

  ////////////////////
  // Reference model
  ////////////////////
  // Returns {overflow, result}, lanes computed on exact integers
  function automatic logic [32:0] expected_of(simd_op_e op, lane_width_e width,
                                              logic [31:0] a, logic [31:0] b);
    int          lw;
    int          cls;
    bit          sgn;
    bit          sub;
    logic [63:0] mask;
    logic [63:0] ua;
    logic [63:0] ub;
    longint      ea;
    longint      eb;
    longint      ex;
    longint      lo;
    longint      hi;
    logic [63:0] lane;
    logic [63:0] res;
    logic        ovf;

    case (op)
      ADD8, SUB8, RADD8, URADD8, RSUB8, URSUB8,
      KADD8, UKADD8, KSUB8, UKSUB8:             lw = 8;
      ADD16, SUB16, RADD16, URADD16, RSUB16, URSUB16,
      KADD16, UKADD16, KSUB16, UKSUB16:         lw = 16;
      ADD32, SUB32, RADD32, URADD32, RSUB32, URSUB32,
      KADD32, UKADD32, KSUB32, UKSUB32:         lw = 32;
      default: lw = (width == W8) ? 8 : ((width == W16) ? 16 : 32);
    endcase

    case (op)
      RADD8, RADD16, RADD32, RSUB8, RSUB16, RSUB32,
      KADD8, KADD16, KADD32, KSUB8, KSUB16, KSUB32,
      SCMPLT, SCMPLE, SMIN, SMAX:               sgn = 1'b1;
      default:                                  sgn = 1'b0;
    endcase

    case (op)
      SUB8, SUB16, SUB32, RSUB8, RSUB16, RSUB32, URSUB8, URSUB16, URSUB32,
      KSUB8, KSUB16, KSUB32, UKSUB8, UKSUB16, UKSUB32: sub = 1'b1;
      default:                                         sub = 1'b0;
    endcase

    case (op)
      ADD8, ADD16, ADD32, SUB8, SUB16, SUB32:           cls = CLS_WRAP;
      RADD8, RADD16, RADD32, URADD8, URADD16, URADD32,
      RSUB8, RSUB16, RSUB32, URSUB8, URSUB16, URSUB32:  cls = CLS_HALVE;
      KADD8, KADD16, KADD32, UKADD8, UKADD16, UKADD32,
      KSUB8, KSUB16, KSUB32, UKSUB8, UKSUB16, UKSUB32:  cls = CLS_SAT;
      CMPEQ:                                            cls = CLS_EQ;
      SCMPLT, UCMPLT:                                   cls = CLS_LT;
      SCMPLE, UCMPLE:                                   cls = CLS_LE;
      SMIN, UMIN:                                       cls = CLS_MIN;
      default:                                          cls = CLS_MAX;
    endcase

    mask = (64'd1 << lw) - 64'd1;
    if (sgn) begin
      lo = -(longint'(1) << (lw - 1));
      hi = (longint'(1) << (lw - 1)) - longint'(1);
    end else begin
      lo = longint'(0);
      hi = longint'(mask);
    end

    res = '0;
    ovf = 1'b0;
    for (int l = 0; l < `SIMD_XLEN / lw; l++) begin
      ua = ({32'd0, a} >> (l * lw)) & mask;
      ub = ({32'd0, b} >> (l * lw)) & mask;
      ea = (sgn && ua[lw - 1]) ? longint'(ua) - (longint'(1) << lw) : longint'(ua);
      eb = (sgn && ub[lw - 1]) ? longint'(ub) - (longint'(1) << lw) : longint'(ub);
      ex = sub ? ea - eb : ea + eb;
      case (cls)
        CLS_WRAP:  lane = 64'(ex) & mask;
        CLS_HALVE: lane = 64'(ex >>> 1) & mask;
        CLS_SAT: begin
          lane = 64'(ex) & mask;
          if (ex > hi) begin
            lane = sat_bound(lw, sgn, 1'b1) & mask;
            ovf  = 1'b1;
          end else if (ex < lo) begin
            lane = sat_bound(lw, sgn, 1'b0) & mask;
            ovf  = 1'b1;
          end
        end
        CLS_EQ:    lane = (ea == eb) ? mask : 64'd0;
        CLS_LT:    lane = (ea < eb) ? mask : 64'd0;
        CLS_LE:    lane = (ea <= eb) ? mask : 64'd0;
        CLS_MIN:   lane = (ea < eb) ? ua : ub;
        default:   lane = (ea < eb) ? ub : ua;
      endcase
      res = res | (lane << (l * lw));
    end
    return {ovf, res[31:0]};
  endfunction

  task automatic report_mismatch(input string signal, input logic [31:0] expected,
                                 input logic [31:0] actual);
    $display("ERR %0t ns %s expected %h actual %h", $time, signal, expected, actual);
    value_errors++;
  endtask

  task automatic report_protocol(input string what);
    $display("At %0t ns the handshake went wrong: %s", $time, what);
    protocol_errors++;
  endtask

  ////////////////////
  // Monitor
  ////////////////////
  // Inputs read here are the levels the DUT saw at the last rising edge
  always @(negedge clk_i) begin
    logic [32:0] expected;

    if (reset_i) begin
      if (ack_i !== 1'b0) report_mismatch("ack_o", 32'd0, 32'(ack_i));
      if (result_i !== '0) report_mismatch("result_o", 32'd0, result_i);
      if (overflow_i !== 1'b0) report_mismatch("overflow_o", 32'd0, 32'(overflow_i));
      req_edges = 0;
      ack_prev  = 1'b0;
    end else begin
      if (req_i) begin
        req_edges++;
      end else begin
        req_edges = 0;
      end

      if (ack_i && !ack_prev) begin
        checks++;
        if (req_edges != 2) begin
          report_protocol($sformatf("ack_o rose %0d edges after req_i, expected 2", req_edges));
        end
        expected = expected_of(op_i, width_i, operand_a_i, operand_b_i);
        if (result_i !== expected[31:0]) begin
          $display("Mismatch on %s", op_i.name());
          report_mismatch("result_o", expected[31:0], result_i);
        end
        if (overflow_i !== expected[32]) begin
          report_mismatch("overflow_o", 32'(expected[32]), 32'(overflow_i));
        end
        held_result   = result_i;
        held_overflow = overflow_i;
      end else if (ack_i) begin
        // Held response must not move
        if (result_i !== held_result) report_mismatch("result_o", held_result, result_i);
        if (overflow_i !== held_overflow) begin
          report_mismatch("overflow_o", 32'(held_overflow), 32'(overflow_i));
        end
      end

      if (ack_i && !req_i) report_protocol("ack_o stayed high after req_i was seen low");
      if (!ack_i && ack_prev && req_i) report_protocol("ack_o fell while req_i was held");
      ack_prev = ack_i;
    end
  end

endmodule

`default_nettype wire

// ==== tb_top.sv ====
////////////////////
// Testbench top for the packed-SIMD unit
// Seeded random four-phase requests that tb_checker checks
////////////////////
`include "simd_settings.svh"
`default_nettype none

module tb_top;

  timeunit 1ns;
  timeprecision 100ps;

  import simd_pkg::*;

  localparam int NUM_OPS         = 400;
  localparam int CLK_PERIOD_NS   = 20;
  localparam int RESET_CYCLES    = 5;
  localparam int ACK_LIMIT       = 8;
  localparam int WATCHDOG_CYCLES = NUM_OPS * 10 + RESET_CYCLES;

  logic                  clk;
  logic                  reset;
  logic                  req;
  simd_op_e              op;
  lane_width_e           width;
  logic [`SIMD_XLEN-1:0] operand_a;
  logic [`SIMD_XLEN-1:0] operand_b;
  logic                  ack;
  logic [`SIMD_XLEN-1:0] result;
  logic                  overflow;
  int                    value_errors;
  int                    protocol_errors;
  int                    checks;
  int                    timeouts = 0;
  int                    seed = 21;

  tb_clock u_clock (
    .clk_o   (clk),
    .reset_o (reset)
  );

  simd_alu DUT (
    .clk_i       (clk),
    .reset_i     (reset),
    .req_i       (req),
    .op_i        (op),
    .width_i     (width),
    .operand_a_i (operand_a),
    .operand_b_i (operand_b),
    .ack_o       (ack),
    .result_o    (result),
    .overflow_o  (overflow)
  );

  tb_checker u_checker (
    .clk_i             (clk),
    .reset_i           (reset),
    .req_i             (req),
    .op_i              (op),
    .width_i           (width),
    .operand_a_i       (operand_a),
    .operand_b_i       (operand_b),
    .ack_i             (ack),
    .result_i          (result),
    .overflow_i        (overflow),
    .value_errors_o    (value_errors),
    .protocol_errors_o (protocol_errors),
    .checks_o          (checks)
  );

  // Half the bytes are lane extremes
  task automatic make_operand(output logic [`SIMD_XLEN-1:0] word);
    logic [31:0] r;
    for (int i = 0; i < `SIMD_NBYTES; i++) begin
      r = $random(seed);
      case (r[2:0])
        3'd0:    word[`SIMD_BYTE*i +: `SIMD_BYTE] = 8'h00;
        3'd1:    word[`SIMD_BYTE*i +: `SIMD_BYTE] = 8'h7f;
        3'd2:    word[`SIMD_BYTE*i +: `SIMD_BYTE] = 8'h80;
        3'd3:    word[`SIMD_BYTE*i +: `SIMD_BYTE] = 8'hff;
        default: word[`SIMD_BYTE*i +: `SIMD_BYTE] = r[15:8];
      endcase
    end
  endtask

  task automatic drive_request();
    logic [31:0]           r;
    logic [`SIMD_XLEN-1:0] a;
    logic [`SIMD_XLEN-1:0] b;
    r = $random(seed);
    make_operand(a);
    make_operand(b);
    op <= simd_op_e'(6'(r % 32'd39));
    case (r[9:8])
      2'd0:    width <= W8;
      2'd1:    width <= W16;
      default: width <= W32;
    endcase
    operand_a <= a;
    operand_b <= b;
    req       <= 1'b1;
  endtask

  task automatic wait_for_ack(input logic level, input int index);
    int waited;
    waited = 0;
    while (ack !== level && waited < ACK_LIMIT) begin
      @(negedge clk);
      waited++;
    end
    if (ack !== level) begin
      $display("Request %0d: ack_o did not reach %0d within %0d cycles", index, level, ACK_LIMIT);
      timeouts++;
    end
  endtask

  task automatic print_summary();
    $display("Summary: %0d results checked, %0d value errors, %0d protocol errors, %0d timeouts",
             checks, value_errors, protocol_errors, timeouts);
  endtask

  ////////////////////
  // Stimulus
  ////////////////////
  initial begin
    logic [31:0] r;

    req       <= 1'b0;
    op        <= ADD8;
    width     <= W8;
    operand_a <= '0;
    operand_b <= '0;
    // First request goes out on the first falling edge after reset
    @(negedge clk);
    while (reset) begin
      @(negedge clk);
    end

    for (int i = 0; i < NUM_OPS; i++) begin
      drive_request();
      wait_for_ack(1'b1, i);
      // Hold req a few cycles as back-pressure
      r = $random(seed);
      repeat (r[1:0]) @(negedge clk);
      req <= 1'b0;
      wait_for_ack(1'b0, i);
      if (r[2]) begin
        @(negedge clk);
      end
    end

    repeat (3) @(negedge clk);
    if (checks != NUM_OPS) begin
      $display("Only %0d of %0d requests were checked", checks, NUM_OPS);
    end
    print_summary();
    if (value_errors == 0 && protocol_errors == 0 && timeouts == 0 && checks == NUM_OPS) begin
      $display("STATUS: PASS");
    end else begin
      $display("STATUS: FAIL");
    end
    $finish;
  end

  // Watchdog
  initial begin
    #(WATCHDOG_CYCLES * CLK_PERIOD_NS);
    $display("Watchdog expired at %0t ns before all requests finished", $time);
    print_summary();
    $display("STATUS: FAIL");
    $finish;
  end

endmodule

`default_nettype wire

// ==== project.f ====
+incdir+.
simd_pkg.sv
simd_op_decode.sv
simd_adder.sv
simd_lane_post.sv
simd_compare.sv
simd_handshake.sv
simd_alu.sv
tb_clock.sv
tb_checker.sv
tb_top.sv

// ==== run_sim.sh ====
#!/bin/sh
# Verilator build and run of tb_top, judged by the pass line in sim.log
rm -f sim.log
verilator --binary --timing --assert --timescale 1ns/100ps --top-module tb_top \
  -f project.f -o tb_top_sim > build.log 2>&1 \
  && ./obj_dir/tb_top_sim > sim.log 2>&1 \
  || echo "Build or run returned an error, see build.log and sim.log"
grep -qx "STATUS: PASS" sim.log 2>/dev/null && echo "Simulation passed" && exit 0
echo "Simulation failed"
exit 1
